//--- design/l2_pkg.sv
// L2 cache shared definitions: line geometry, sizing, request and response packets, enums
`default_nettype none

package l2_pkg;

	// Line geometry, a line is sixteen 32-bit words
	localparam int CACHE_LINE_WORDS = 16;
	localparam int CACHE_LINE_BYTES = CACHE_LINE_WORDS * 4;
	localparam int CACHE_LINE_BITS = CACHE_LINE_WORDS * 32;

	// Store sizing, the line index sits right above the byte offset in the address
	localparam int L2_LINES = 256;
	localparam int L2_INDEX_WIDTH = 8;

	// Client sizing
	localparam int NUM_CORES = 2;
	localparam int CORE_ID_WIDTH = 1;
	localparam int REQ_ID_WIDTH = 2;

	// Request codes, the two upper codes are reserved and get swallowed
	typedef enum logic [1:0]
	{
		L2REQ_LOAD = 2'd0,
		L2REQ_STORE = 2'd1,
		L2REQ_RESERVED2 = 2'd2,
		L2REQ_RESERVED3 = 2'd3
	} l2req_type_t;

	// Acknowledge codes
	typedef enum logic
	{
		L2RSP_LOAD_ACK = 1'b0,
		L2RSP_STORE_ACK = 1'b1
	} l2rsp_type_t;

	// Which L1 the request came from
	typedef enum logic
	{
		CT_ICACHE = 1'b0,
		CT_DCACHE = 1'b1
	} cache_type_t;

	// Control FSM, the second state is the bubble while a store writes back
	typedef enum logic
	{
		L2_ACCEPT = 1'b0,
		L2_STORE_WRITE = 1'b1
	} l2_state_t;

	// Request from an L1, byte lane i of data pairs with store_mask bit i
	typedef struct packed
	{
		logic valid;
		logic [CORE_ID_WIDTH-1:0] core;
		logic [REQ_ID_WIDTH-1:0] id;
		l2req_type_t packet_type;
		cache_type_t cache_type;
		logic [31:0] address;
		logic [CACHE_LINE_BYTES-1:0] store_mask;
		logic [CACHE_LINE_BITS-1:0] data;
	} l2req_packet_t;

	// Response broadcast to all L1s, data is the line after the request was applied
	typedef struct packed
	{
		logic valid;
		logic [CORE_ID_WIDTH-1:0] core;
		logic [REQ_ID_WIDTH-1:0] id;
		l2rsp_type_t packet_type;
		cache_type_t cache_type;
		logic [31:0] address;
		logic [CACHE_LINE_BITS-1:0] data;
	} l2rsp_packet_t;

endpackage

`default_nettype wire

//--- design/l2_request_arbiter.sv
// Round-robin arbiter choosing one of the client request ports per cycle
`timescale 1ns/1ps
`default_nettype none

module l2_request_arbiter
	import l2_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire l2req_packet_t l2i_request[NUM_CORES],
	input wire logic accept_enable,
	output logic l2_ready[NUM_CORES],
	output l2req_packet_t granted_request
);

	// Client that has first claim in the current cycle
	logic [CORE_ID_WIDTH-1:0] rr_pointer;

	// Winner of the search, valid only when grant_found is set
	logic grant_found;
	logic [CORE_ID_WIDTH-1:0] grant_index;

	// Acceptance happens when control is open and someone is asking
	logic grant_taken;

	// Walk the clients starting at the pointer and stop at the first valid one
	always_comb
	begin
		int candidate;

		grant_found = 1'b0;
		grant_index = '0;
		for (int offset = 0; offset < NUM_CORES; offset++)
		begin
			candidate = (int'(rr_pointer) + offset) % NUM_CORES;
			if (!grant_found && l2i_request[candidate].valid)
			begin
				grant_found = 1'b1;
				grant_index = CORE_ID_WIDTH'(candidate);
			end
		end
	end

	assign grant_taken = accept_enable && grant_found;

	// Ready goes only to the winner, and only while control can take a request
	always_comb
	begin
		for (int i = 0; i < NUM_CORES; i++)
			l2_ready[i] = grant_taken && (grant_index == CORE_ID_WIDTH'(i));
	end

	// Forward the winning packet, valid says whether it is accepted this edge
	always_comb
	begin
		granted_request = l2i_request[grant_index];
		granted_request.valid = grant_taken;
	end

	// Move priority to the client after the winner so both sides get turns
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rr_pointer <= '0;
		end
		else if (grant_taken)
		begin
			if (int'(grant_index) == NUM_CORES - 1)
				rr_pointer <= '0;
			else
				rr_pointer <= grant_index + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/l2_control.sv
// L2 control: accepts a request, sequences the store write-back and registers the response
`timescale 1ns/1ps
`default_nettype none

module l2_control
	import l2_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire l2req_packet_t granted_request,
	input wire logic [CACHE_LINE_BITS-1:0] read_line,
	input wire logic [CACHE_LINE_BITS-1:0] merged_line,
	output logic accept_enable,
	output logic [L2_INDEX_WIDTH-1:0] read_index,
	output logic [L2_INDEX_WIDTH-1:0] write_index,
	output logic write_enable,
	output l2req_packet_t stage_request,
	output l2rsp_packet_t l2_response
);

	// Bit position of the line index inside a byte address
	localparam int INDEX_LSB = $clog2(CACHE_LINE_BYTES);

	l2_state_t state;

	// The single request stage, the valid bit is kept apart so only it needs a reset
	logic stage_valid;
	l2req_packet_t stage_payload;

	// Decode of the staged request
	logic stage_has_response;
	l2rsp_type_t stage_rsp_type;
	logic stage_is_store;

	// Response register, again with the valid bit split off
	l2rsp_packet_t rsp_next;
	logic rsp_valid;
	l2rsp_packet_t rsp_payload;

	// New requests only while not writing back a store
	assign accept_enable = (state == L2_ACCEPT);

	// Address the line store with the incoming request so the old line is ready next cycle
	assign read_index = granted_request.address[INDEX_LSB +: L2_INDEX_WIDTH];

	// Store bubble: one cycle closed after each accepted store
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= L2_ACCEPT;
		else if (state == L2_ACCEPT && granted_request.valid
			&& granted_request.packet_type == L2REQ_STORE)
			state <= L2_STORE_WRITE;
		else
			state <= L2_ACCEPT;
	end

	// Stage fills on acceptance and empties when nothing is accepted
	always_ff @(posedge clk)
	begin
		if (reset)
			stage_valid <= 1'b0;
		else
			stage_valid <= granted_request.valid;
	end

	always_ff @(posedge clk)
	begin
		if (granted_request.valid)
			stage_payload <= granted_request;
	end

	always_comb
	begin
		stage_request = stage_payload;
		stage_request.valid = stage_valid;
	end

	// Loads and stores get acknowledged, reserved codes are dropped here
	always_comb
	begin
		stage_has_response = 1'b0;
		stage_rsp_type = L2RSP_LOAD_ACK;
		case (stage_payload.packet_type)
			L2REQ_LOAD:
			begin
				stage_has_response = 1'b1;
				stage_rsp_type = L2RSP_LOAD_ACK;
			end
			L2REQ_STORE:
			begin
				stage_has_response = 1'b1;
				stage_rsp_type = L2RSP_STORE_ACK;
			end
			default:
			begin
				stage_has_response = 1'b0;
			end
		endcase
	end

	assign stage_is_store = (stage_payload.packet_type == L2REQ_STORE);

	// Merged line goes back to the store in the same edge the response is registered
	assign write_enable = stage_valid && stage_is_store;
	assign write_index = stage_payload.address[INDEX_LSB +: L2_INDEX_WIDTH];

	// Response echoes the request and carries the line as it is after this request
	always_comb
	begin
		rsp_next.valid = stage_valid && stage_has_response;
		rsp_next.core = stage_payload.core;
		rsp_next.id = stage_payload.id;
		rsp_next.packet_type = stage_rsp_type;
		rsp_next.cache_type = stage_payload.cache_type;
		rsp_next.address = stage_payload.address;
		rsp_next.data = stage_is_store ? merged_line : read_line;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= rsp_next.valid;
	end

	always_ff @(posedge clk)
	begin
		if (stage_valid)
			rsp_payload <= rsp_next;
	end

	// Valid is a single-cycle pulse, nothing can stall it
	always_comb
	begin
		l2_response = rsp_payload;
		l2_response.valid = rsp_valid;
	end

endmodule

`default_nettype wire

//--- design/l2_line_store.sv
// Line-wide L2 storage with a registered read-first port and a byte-enabled write port
`timescale 1ns/1ps
`default_nettype none

module l2_line_store
	import l2_pkg::*;
(
	input wire logic clk,
	input wire logic [L2_INDEX_WIDTH-1:0] read_index,
	output logic [CACHE_LINE_BITS-1:0] read_line,
	input wire logic write_enable,
	input wire logic [L2_INDEX_WIDTH-1:0] write_index,
	input wire logic [CACHE_LINE_BYTES-1:0] byte_enable,
	input wire logic [CACHE_LINE_BITS-1:0] write_line
);

	// Whole address space lives here, one entry per line
	logic [CACHE_LINE_BITS-1:0] lines[L2_LINES];

	// Memory starts out as all zeros
	initial
	begin
		for (int i = 0; i < L2_LINES; i++)
			lines[i] = '0;
	end

	// Read returns the contents from before any write at the same edge
	always_ff @(posedge clk)
	begin
		read_line <= lines[read_index];
	end

	// Only lanes with their enable set are updated
	always_ff @(posedge clk)
	begin
		if (write_enable)
		begin
			for (int i = 0; i < CACHE_LINE_BYTES; i++)
			begin
				if (byte_enable[i])
					lines[write_index][8 * i +: 8] <= write_line[8 * i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/l2_store_merge.sv
// Store merge: overlays masked store bytes on the old line and drives the write byte enables
`timescale 1ns/1ps
`default_nettype none

module l2_store_merge
	import l2_pkg::*;
(
	input wire l2req_packet_t stage_request,
	input wire logic [CACHE_LINE_BITS-1:0] read_line,
	output logic [CACHE_LINE_BITS-1:0] merged_line,
	output logic [CACHE_LINE_BYTES-1:0] byte_enable
);

	// Pick each byte lane from the store data or from the current line
	always_comb
	begin
		for (int i = 0; i < CACHE_LINE_BYTES; i++)
		begin
			if (stage_request.store_mask[i])
				merged_line[8 * i +: 8] = stage_request.data[8 * i +: 8];
			else
				merged_line[8 * i +: 8] = read_line[8 * i +: 8];
		end
	end

	// The line store only needs to touch the lanes the L1 actually wrote
	assign byte_enable = stage_request.store_mask;

endmodule

`default_nettype wire

//--- design/l2_subsystem.sv
// L2 subsystem top: arbiter, control, line store and store merge wired together
`timescale 1ns/1ps
`default_nettype none

module l2_subsystem
	import l2_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire l2req_packet_t l2i_request[NUM_CORES],
	output logic l2_ready[NUM_CORES],
	output l2rsp_packet_t l2_response
);

	// Arbiter to control
	logic accept_enable;
	l2req_packet_t granted_request;

	// Control to line store and merge
	logic [L2_INDEX_WIDTH-1:0] read_index;
	logic [L2_INDEX_WIDTH-1:0] write_index;
	logic write_enable;
	l2req_packet_t stage_request;

	// Data paths around the line store
	logic [CACHE_LINE_BITS-1:0] read_line;
	logic [CACHE_LINE_BITS-1:0] merged_line;
	logic [CACHE_LINE_BYTES-1:0] byte_enable;

	l2_request_arbiter i_l2_request_arbiter (
		.clk(clk),
		.reset(reset),
		.l2i_request(l2i_request),
		.accept_enable(accept_enable),
		.l2_ready(l2_ready),
		.granted_request(granted_request)
	);

	l2_control i_l2_control (
		.clk(clk),
		.reset(reset),
		.granted_request(granted_request),
		.read_line(read_line),
		.merged_line(merged_line),
		.accept_enable(accept_enable),
		.read_index(read_index),
		.write_index(write_index),
		.write_enable(write_enable),
		.stage_request(stage_request),
		.l2_response(l2_response)
	);

	// Merged line is both written back and returned in the store acknowledge
	l2_line_store i_l2_line_store (
		.clk(clk),
		.read_index(read_index),
		.read_line(read_line),
		.write_enable(write_enable),
		.write_index(write_index),
		.byte_enable(byte_enable),
		.write_line(merged_line)
	);

	l2_store_merge i_l2_store_merge (
		.stage_request(stage_request),
		.read_line(read_line),
		.merged_line(merged_line),
		.byte_enable(byte_enable)
	);

endmodule

`default_nettype wire

//--- sim/l2_subsystem_tb.sv
// L2 subsystem testbench: two client request streams checked against a shadow memory model
`timescale 1ns/1ps
`default_nettype none

module l2_subsystem_tb
	import l2_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	// Requests issued by the six tests, in the order they run
	localparam int TOTAL_REQUESTS = 6 + 4 + 12 + 4 + 12 + 3;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * TOTAL_REQUESTS;
	localparam logic [7:0] LINE_A = 8'h40;
	localparam logic [7:0] LINE_B = 8'h41;
	localparam logic [7:0] LINE_C = 8'h80;

	logic clk;
	logic reset;
	l2req_packet_t l2i_request[NUM_CORES];
	logic l2_ready[NUM_CORES];
	l2rsp_packet_t l2_response;

	// Shadow copy of the line store and the responses the DUT still owes
	logic [CACHE_LINE_BITS-1:0] shadow[L2_LINES];
	l2req_packet_t client_queue[NUM_CORES][$];
	l2rsp_packet_t expected_queue[$];
	int expected_cycle[$];

	// Which client won each grant of the running test, and in which cycle
	int accept_core[$];
	int accept_cycle[$];

	int next_id[NUM_CORES];
	int cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int tests_failed = 0;
	int test_number = 0;
	int errors_before = 0;

	l2_subsystem i_l2_subsystem (
		.clk(clk),
		.reset(reset),
		.l2i_request(l2i_request),
		.l2_ready(l2_ready),
		.l2_response(l2_response)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	function automatic logic [CACHE_LINE_BITS-1:0] random_line();
		logic [CACHE_LINE_BITS-1:0] value;
		for (int w = 0; w < CACHE_LINE_WORDS; w++)
			value[32 * w +: 32] = $urandom;
		return value;
	endfunction

	function automatic logic [CACHE_LINE_BYTES-1:0] random_mask();
		return {$urandom, $urandom};
	endfunction

	// Random bits above the index make most accesses aliases of the same line
	function automatic logic [31:0] line_address(input logic [7:0] index);
		logic [31:0] upper;
		upper = $urandom;
		return {upper[17:0], index, upper[31:26]};
	endfunction

	// Reference model: a store overwrites the masked bytes, anything else leaves the line alone
	function automatic logic [CACHE_LINE_BITS-1:0] expected_line(input l2req_packet_t req);
		logic [CACHE_LINE_BITS-1:0] line;
		line = shadow[req.address[13:6]];
		if (req.packet_type == L2REQ_STORE)
		begin
			for (int b = 0; b < CACHE_LINE_BYTES; b++)
				if (req.store_mask[b])
					line[8 * b +: 8] = req.data[8 * b +: 8];
		end
		return line;
	endfunction

	task automatic expect_equal(input string what, input logic [CACHE_LINE_BITS-1:0] got,
		input logic [CACHE_LINE_BITS-1:0] want);
		check_count++;
		assert (got === want)
		else
		begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
			error_count++;
		end
	endtask

	// Loads carry random data and mask too, the DUT has to ignore both
	task automatic queue_request(input int c, input l2req_type_t code, input logic [31:0] address,
		input logic [CACHE_LINE_BYTES-1:0] mask);
		l2req_packet_t req;
		req.valid = 1'b1;
		req.core = CORE_ID_WIDTH'(c);
		req.id = REQ_ID_WIDTH'(next_id[c]);
		req.packet_type = code;
		req.cache_type = ($urandom % 2 == 0) ? CT_ICACHE : CT_DCACHE;
		req.address = address;
		req.store_mask = mask;
		req.data = random_line();
		next_id[c] = (next_id[c] + 1) % 4;
		client_queue[c].push_back(req);
	endtask

	// A response is due two edges after its acceptance edge, as seen before the edge updates
	task automatic check_response();
		l2rsp_packet_t want;
		if (l2_response.valid)
		begin
			check_count++;
			assert (expected_queue.size() > 0)
			else
			begin
				$display("A response for core %0d id %0d came at %0t with no request waiting",
					l2_response.core, l2_response.id, $time);
				error_count++;
			end
			if (expected_queue.size() > 0)
			begin
				want = expected_queue.pop_front();
				expect_equal("response cycle", cycle, expected_cycle.pop_front());
				expect_equal("core", l2_response.core, want.core);
				expect_equal("id", l2_response.id, want.id);
				expect_equal("packet type", l2_response.packet_type, want.packet_type);
				expect_equal("cache type", l2_response.cache_type, want.cache_type);
				expect_equal("address", l2_response.address, want.address);
				expect_equal("line data", l2_response.data, want.data);
			end
		end
		else if (expected_queue.size() > 0)
		begin
			assert (expected_cycle[0] > cycle)
			else
			begin
				want = expected_queue.pop_front();
				void'(expected_cycle.pop_front());
				$display("The request from core %0d id %0d got no response in time (at %0t)",
					want.core, want.id, $time);
				error_count++;
			end
		end
	endtask

	// Response check and acceptance bookkeeping both use values from just before the edge
	always @(posedge clk)
	begin
		l2req_packet_t req;
		l2rsp_packet_t want;
		if (!reset)
		begin
			check_response();
			for (int c = 0; c < NUM_CORES; c++)
			begin
				if (l2i_request[c].valid && l2_ready[c])
				begin
					req = l2i_request[c];
					void'(client_queue[c].pop_front());
					accept_core.push_back(c);
					accept_cycle.push_back(cycle);
					if (req.packet_type == L2REQ_LOAD || req.packet_type == L2REQ_STORE)
					begin
						want.valid = 1'b1;
						want.core = req.core;
						want.id = req.id;
						want.packet_type = (req.packet_type == L2REQ_STORE) ?
							L2RSP_STORE_ACK : L2RSP_LOAD_ACK;
						want.cache_type = req.cache_type;
						want.address = req.address;
						want.data = expected_line(req);
						expected_queue.push_back(want);
						expected_cycle.push_back(cycle + 2);
					end
					shadow[req.address[13:6]] = expected_line(req);
				end
			end
		end
		cycle++;
	end

	// Each client presents the head of its queue until it is accepted
	always @(negedge clk)
	begin
		for (int c = 0; c < NUM_CORES; c++)
		begin
			if (client_queue[c].size() > 0)
				l2i_request[c] = client_queue[c][0];
			else
				l2i_request[c] = '0;
		end
	end

	task automatic wait_idle();
		do
			@(negedge clk);
		while (client_queue[0].size() + client_queue[1].size() + expected_queue.size() > 0);
		// A couple of quiet cycles so a stray response still gets caught in this test
		repeat (2)
			@(negedge clk);
	endtask

	task automatic begin_test();
		test_number++;
		errors_before = error_count;
		accept_core.delete();
		accept_cycle.delete();
		@(posedge clk);
	endtask

	task automatic report_test(input string name);
		if (error_count == errors_before)
			$display("Test %0d %s: passed", test_number, name);
		else
		begin
			$display("Test %0d %s: failed with %0d errors", test_number, name,
				error_count - errors_before);
			tests_failed++;
		end
	endtask

	initial
	begin
		logic [7:0] index;
		void'($urandom(32'hb36b_4a53));
		reset = 1'b1;
		for (int c = 0; c < NUM_CORES; c++)
		begin
			l2i_request[c] = '0;
			next_id[c] = 0;
		end
		for (int i = 0; i < L2_LINES; i++)
			shadow[i] = '0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test();
		for (int i = 0; i < 6; i++)
			queue_request(i % 2, L2REQ_LOAD, line_address(8'(16 + i)), random_mask());
		wait_idle();
		report_test("loads from untouched lines");

		begin_test();
		queue_request(1, L2REQ_STORE, line_address(LINE_A), '1);
		queue_request(1, L2REQ_LOAD, line_address(LINE_A), random_mask());
		queue_request(0, L2REQ_STORE, line_address(LINE_B), '1);
		queue_request(0, L2REQ_LOAD, line_address(LINE_B), random_mask());
		wait_idle();
		report_test("full-mask store and reload");

		// Two partial stores on top of each other, then a load through yet another alias
		begin_test();
		for (int i = 0; i < 4; i++)
		begin
			index = 8'($urandom);
			queue_request(i % 2, L2REQ_STORE, line_address(index), {$urandom, $urandom});
			queue_request(i % 2, L2REQ_STORE, line_address(index), {$urandom, $urandom});
			queue_request(i % 2, L2REQ_LOAD, line_address(index), random_mask());
		end
		wait_idle();
		report_test("partial-mask merge with aliasing");

		begin_test();
		queue_request(0, L2REQ_STORE, line_address(LINE_C), {$urandom, $urandom});
		queue_request(0, L2REQ_LOAD, line_address(LINE_C), random_mask());
		queue_request(0, L2REQ_STORE, line_address(LINE_C + 8'd1), {$urandom, $urandom});
		queue_request(0, L2REQ_LOAD, line_address(LINE_C + 8'd1), random_mask());
		wait_idle();
		for (int i = 0; i + 1 < accept_cycle.size(); i += 2)
			expect_equal("cycles from store to load", accept_cycle[i + 1] - accept_cycle[i], 2);
		report_test("store followed by load");

		begin_test();
		for (int i = 0; i < 6; i++)
		begin
			queue_request(0, L2REQ_LOAD, line_address(8'($urandom)), random_mask());
			queue_request(1, L2REQ_LOAD, line_address(8'($urandom)), random_mask());
		end
		wait_idle();
		for (int i = 1; i < accept_core.size(); i++)
		begin
			expect_equal("client of grant", accept_core[i], 1 - accept_core[i - 1]);
			expect_equal("cycles between grants", accept_cycle[i] - accept_cycle[i - 1], 1);
		end
		report_test("two clients streaming loads");

		begin_test();
		queue_request(0, L2REQ_RESERVED2, line_address(LINE_A), '1);
		queue_request(0, L2REQ_RESERVED3, line_address(LINE_A), '1);
		queue_request(0, L2REQ_LOAD, line_address(LINE_A), random_mask());
		wait_idle();
		report_test("unused request codes");

		$display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			test_number, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/l2_pkg.sv
design/l2_request_arbiter.sv
design/l2_control.sv
design/l2_line_store.sv
design/l2_store_merge.sv
design/l2_subsystem.sv
sim/l2_subsystem_tb.sv

//--- Bender.yml
package:
  name: l2_subsystem

sources:
  - design/l2_pkg.sv
  - design/l2_request_arbiter.sv
  - design/l2_control.sv
  - design/l2_line_store.sv
  - design/l2_store_merge.sv
  - design/l2_subsystem.sv
  - target: simulation
    files:
      - sim/l2_subsystem_tb.sv
